//--- Makefile
# Verilator build for the posit adder regression.

VERILATOR ?= verilator
TOP       ?= ppu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) $(VFLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src.f
+incdir+verilog
verilog/ppu_pkg.sv
verilog/core_add.sv
verilog/core_sub.sv
verilog/posit_operand_decode.sv
verilog/core_add_sub.sv
verilog/posit_encode.sv
verilog/ppu_top.sv
verification/clk_gen.sv
verification/ppu_tb.sv

//--- verification/clk_gen.sv
/*
  Testbench clock and synchronous reset generator.
*/
`timescale 1ns/10ps

module clk_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- verification/ppu_tb.sv
/*
  Regression for the posit adder: exact sums, specials, operand order,
  random identities and saturation, with a fixed latency of three cycles.
*/
`timescale 1ns/10ps

module ppu_tb;

  localparam int RESET_CYCLES = 5;
  localparam int LATENCY = 3;
  localparam int NUM_RANDOM = 40;
  localparam int HOLD_CYCLES = 4;
  localparam ppu_pkg::posit_t NAR = 16'h8000;

  typedef struct packed {
    ppu_pkg::op_e    op;
    ppu_pkg::posit_t a;
    ppu_pkg::posit_t b;
    ppu_pkg::posit_t expected;
  } vector_t;

  typedef struct packed {
    vector_t     vec;
    logic [31:0] issue_cycle;
  } pending_t;

  logic clk, rst;
  logic valid_in, valid_out;
  ppu_pkg::op_e op_in;
  ppu_pkg::posit_t a_in, b_in, result_out;

  ppu_pkg::posit_t exp_word; // Travels with the driven inputs.
  ppu_pkg::posit_t last_expected;
  vector_t table_q[$];
  pending_t pending_q[$];
  pending_t in_flight, retired;
  int cycle, cycle_limit, checks, errors, seed;

  clk_gen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) clk_gen_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  ppu_top uut (
    .clk_i    (clk),
    .rst_i    (rst),
    .valid_i  (valid_in),
    .op_i     (op_in),
    .a_i      (a_in),
    .b_i      (b_in),
    .valid_o  (valid_out),
    .result_o (result_out)
  );

  function automatic ppu_pkg::posit_t negate_posit(input ppu_pkg::posit_t p);
    return ~p + 1'b1;
  endfunction

  task automatic add_vector(input ppu_pkg::op_e op, input ppu_pkg::posit_t a, b, expected);
    vector_t v;
    v.op = op;
    v.a = a;
    v.b = b;
    v.expected = expected;
    table_q.push_back(v);
  endtask

  task automatic load_table();
    add_vector(ppu_pkg::OP_ADD, 16'h4000, 16'h4000, 16'h5000); // 1 + 1 = 2.
    add_vector(ppu_pkg::OP_ADD, 16'h4800, 16'h4800, 16'h5800); // Carry, 1.5 + 1.5 = 3.
    add_vector(ppu_pkg::OP_ADD, 16'h4000, 16'h5000, 16'h5800);
    add_vector(ppu_pkg::OP_ADD, 16'h4000, 16'h3000, 16'h4800);
    add_vector(ppu_pkg::OP_ADD, 16'h5000, 16'h5000, 16'h6000); // Regime grows.
    add_vector(ppu_pkg::OP_SUB, 16'h4000, 16'h3800, 16'h2000); // Cancellation.
    add_vector(ppu_pkg::OP_SUB, 16'h5800, 16'h4000, 16'h5000);
    add_vector(ppu_pkg::OP_SUB, 16'h4000, 16'h5000, 16'hC000); // 1 - 2 = -1.
    // Wide gaps, minpos only reaches sticky.
    add_vector(ppu_pkg::OP_ADD, 16'h4000, 16'h0001, 16'h4000);
    add_vector(ppu_pkg::OP_SUB, 16'h4000, 16'h0001, 16'h4000);
    // Half-ulp addend, ties to even.
    add_vector(ppu_pkg::OP_ADD, 16'h4000, 16'h00C0, 16'h4000);
    add_vector(ppu_pkg::OP_ADD, 16'h4001, 16'h00C0, 16'h4002);
    add_vector(ppu_pkg::OP_ADD, NAR, 16'h4000, NAR);
    add_vector(ppu_pkg::OP_SUB, 16'h4000, NAR, NAR);
    add_vector(ppu_pkg::OP_ADD, 16'h0000, 16'h4800, 16'h4800);
    add_vector(ppu_pkg::OP_SUB, 16'h4800, 16'h4800, 16'h0000);
    add_vector(ppu_pkg::OP_SUB, 16'h0000, 16'h4000, 16'hC000);
    add_vector(ppu_pkg::OP_ADD, 16'h7FFF, 16'h7FFF, 16'h7FFF); // Saturates at maxpos.
    add_vector(ppu_pkg::OP_ADD, 16'h8001, 16'h8001, 16'h8001);
    add_vector(ppu_pkg::OP_SUB, 16'h4000, 16'hC000, 16'h5000); // 1 - (-1).
    add_vector(ppu_pkg::OP_ADD, 16'hC000, 16'hB000, 16'hA800); // -1 + -2 = -3.
    add_vector(ppu_pkg::OP_ADD, 16'h5800, 16'hC000, 16'h5000);
  endtask

  task automatic issue(input ppu_pkg::op_e op, input ppu_pkg::posit_t a, b, expected);
    @(posedge clk);
    valid_in <= 1'b1;
    op_in <= op;
    a_in <= a;
    b_in <= b;
    exp_word <= expected;
    last_expected = expected;
  endtask

  task automatic run_random_identities();
    ppu_pkg::posit_t a;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = ppu_pkg::posit_t'($random(seed));
      while (a == NAR) begin
        a = ppu_pkg::posit_t'($random(seed));
      end
      issue(ppu_pkg::OP_ADD, a, 16'h0000, a);
      issue(ppu_pkg::OP_ADD, 16'h0000, a, a);
      issue(ppu_pkg::OP_SUB, a, a, 16'h0000);
      issue(ppu_pkg::OP_ADD, a, negate_posit(a), 16'h0000);
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      errors++;
      $display("Timeout: results still missing after %0d cycles", cycle_limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Regression failed");
      $finish;
    end
  end

  // Outputs and queued strobes are sampled half a cycle after the edge.
  always @(negedge clk) begin
    if (valid_out === 1'b1) begin
      if (pending_q.size() == 0) begin
        errors++;
        $display("valid_o asserted at cycle %0d with no operation in flight", cycle);
      end else begin
        retired = pending_q.pop_front();
        checks++;
        if (cycle - int'(retired.issue_cycle) != LATENCY) begin
          errors++;
          $display("valid_o came %0d cycles after its strobe instead of %0d",
                   cycle - int'(retired.issue_cycle), LATENCY);
        end
        if (result_out !== retired.vec.expected) begin
          errors++;
          $display("[ERROR] result_o: 0x%04h %s 0x%04h expected 0x%04h, got 0x%04h",
                   retired.vec.a, (retired.vec.op == ppu_pkg::OP_SUB) ? "-" : "+",
                   retired.vec.b, retired.vec.expected, result_out);
        end
      end
    end
    if (valid_in) begin
      in_flight.vec.op = op_in;
      in_flight.vec.a = a_in;
      in_flight.vec.b = b_in;
      in_flight.vec.expected = exp_word;
      in_flight.issue_cycle = cycle;
      pending_q.push_back(in_flight);
    end
  end

  initial begin
    valid_in = 1'b0;
    op_in = ppu_pkg::OP_ADD;
    a_in = '0;
    b_in = '0;
    exp_word = '0;
    last_expected = '0;
    cycle = 0;
    checks = 0;
    errors = 0;
    seed = 2;
    load_table();
    cycle_limit = RESET_CYCLES + 2 * table_q.size() + 4 * NUM_RANDOM + HOLD_CYCLES + 20;

    @(negedge rst);
    @(negedge clk);
    checks++;
    if (valid_out !== 1'b0) begin
      errors++;
      $display("[ERROR] valid_o after reset: expected 0x0, got 0x%0h", valid_out);
    end
    if (result_out !== 16'h0000) begin
      errors++;
      $display("[ERROR] result_o after reset: expected 0x0000, got 0x%04h", result_out);
    end

    run_random_identities();
    foreach (table_q[i]) begin
      issue(table_q[i].op, table_q[i].a, table_q[i].b, table_q[i].expected);
      if (table_q[i].op == ppu_pkg::OP_ADD) begin
        issue(ppu_pkg::OP_ADD, table_q[i].b, table_q[i].a, table_q[i].expected);
      end else begin
        issue(ppu_pkg::OP_ADD, table_q[i].a, negate_posit(table_q[i].b), table_q[i].expected);
      end
    end
    @(posedge clk);
    valid_in <= 1'b0;
    a_in <= NAR; // Idle operands would give a different word.
    b_in <= NAR;
    while (pending_q.size() != 0) begin
      @(posedge clk);
    end

    // Output word holds while idle.
    repeat (HOLD_CYCLES) @(posedge clk);
    @(negedge clk);
    checks++;
    if (result_out !== last_expected) begin
      errors++;
      $display("[ERROR] result_o while idle: expected 0x%04h, got 0x%04h",
               last_expected, result_out);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verilog/core_add.sv
/*
  Normalizer for effective addition: folds a carry back into the mantissa.
*/
`timescale 1ns/10ps
`include "ppu_defines.svh"

module core_add (
  input  ppu_pkg::mant_sum_t  mant_i,
  input  ppu_pkg::exponent_t  te_diff_i,
  output ppu_pkg::mant_sum_t  new_mant_o,
  output ppu_pkg::exponent_t  new_te_diff_o,
  output logic                frac_truncated_o
);

  logic carry;

  assign carry = mant_i[`PPU_MANT_ADD_RESULT_SIZE-1];

  // Sum in [2,4) moves back to [1,2).
  assign new_mant_o = carry ? mant_i >> 1 : mant_i;
  assign new_te_diff_o = te_diff_i + ppu_pkg::exponent_t'(carry);

  assign frac_truncated_o = carry & mant_i[0]; // Bit lost by the shift.

endmodule

//--- verilog/core_add_sub.sv
/*
  Execute stage: aligns mantissa 2 to mantissa 1, sums them and normalizes.
  Operand 1 is expected to have the larger magnitude.
*/
`timescale 1ns/10ps
`include "ppu_defines.svh"

module core_add_sub (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  ppu_pkg::operands_t    operands_i,
  output ppu_pkg::normalized_t  normalized_o,
  output logic                  valid_o
);

  localparam int UP_W = `PPU_MANT_SIZE + `PPU_MAX_TE_DIFF;

  ppu_pkg::exponent_t te_diff_st0, te_diff_st1, te2_st1;
  logic [UP_W-1:0] mant1_up, mant2_up, mant2_addend;
  ppu_pkg::mant_sum_t mant_sum_st0, mant_sum_st1;
  logic opposite_st1, sign_st1, valid_st1;
  ppu_pkg::special_e special_st1;
  ppu_pkg::posit_t pass_st1;

  assign te_diff_st0 = operands_i.te1 - operands_i.te2;

  assign mant1_up = {operands_i.mant1, {`PPU_MAX_TE_DIFF{1'b0}}};
  assign mant2_up = {operands_i.mant2, {`PPU_MAX_TE_DIFF{1'b0}}} >> te_diff_st0;
  assign mant2_addend = operands_i.have_opposite_sign ? ~mant2_up + 1'b1 : mant2_up;
  assign mant_sum_st0 = {1'b0, mant1_up} + {1'b0, mant2_addend};

  generate
    if (`PIPELINE_STAGE) begin : g_pipe
      always_ff @(posedge clk_i) begin
        if (rst_i) begin
          valid_st1 <= 1'b0;
        end else begin
          valid_st1 <= valid_i;
        end
      end

      always_ff @(posedge clk_i) begin
        te_diff_st1 <= te_diff_st0;
        mant_sum_st1 <= mant_sum_st0;
        te2_st1 <= operands_i.te2;
        opposite_st1 <= operands_i.have_opposite_sign;
        sign_st1 <= operands_i.sign1;
        special_st1 <= operands_i.special;
        pass_st1 <= operands_i.pass_value;
      end
    end else begin : g_comb
      assign valid_st1 = valid_i;
      assign te_diff_st1 = te_diff_st0;
      assign mant_sum_st1 = mant_sum_st0;
      assign te2_st1 = operands_i.te2;
      assign opposite_st1 = operands_i.have_opposite_sign;
      assign sign_st1 = operands_i.sign1;
      assign special_st1 = operands_i.special;
      assign pass_st1 = operands_i.pass_value;
    end
  endgenerate

  ppu_pkg::mant_sum_t mant_add;
  ppu_pkg::exponent_t te_diff_add;
  logic add_truncated;

  core_add core_add_inst (
    .mant_i           (mant_sum_st1),
    .te_diff_i        (te_diff_st1),
    .new_mant_o       (mant_add),
    .new_te_diff_o    (te_diff_add),
    .frac_truncated_o (add_truncated)
  );

  logic [`PPU_MANT_SUB_RESULT_SIZE-1:0] mant_sub;
  ppu_pkg::exponent_t te_diff_sub;

  // Carry out of a subtraction is dropped.
  core_sub core_sub_inst (
    .mant_i        (mant_sum_st1[`PPU_MANT_SUB_RESULT_SIZE-1:0]),
    .te_diff_i     (te_diff_st1),
    .new_mant_o    (mant_sub),
    .new_te_diff_o (te_diff_sub)
  );

  ppu_pkg::exponent_t te_diff_updated;

  assign te_diff_updated = opposite_st1 ? te_diff_sub : te_diff_add;

  assign normalized_o.sign = sign_st1;
  assign normalized_o.te = te2_st1 + te_diff_updated;
  assign normalized_o.mant = opposite_st1 ? {1'b0, mant_sub} : mant_add;
  assign normalized_o.frac_truncated = ~opposite_st1 & add_truncated;
  assign normalized_o.special = special_st1;
  assign normalized_o.pass_value = pass_st1;

  assign valid_o = valid_st1;

endmodule

//--- verilog/core_sub.sv
/*
  Normalizer for effective subtraction: removes leading zeros left by
  cancellation and lowers the exponent to match.
*/
`timescale 1ns/10ps
`include "ppu_defines.svh"

module core_sub (
  input  logic [`PPU_MANT_SUB_RESULT_SIZE-1:0]  mant_i,
  input  ppu_pkg::exponent_t                    te_diff_i,
  output logic [`PPU_MANT_SUB_RESULT_SIZE-1:0]  new_mant_o,
  output ppu_pkg::exponent_t                    new_te_diff_o
);

  localparam int W = `PPU_MANT_SUB_RESULT_SIZE;
  localparam int LZ_BITS = $clog2(W);

  logic [LZ_BITS-1:0] lz;

  // Highest set bit wins, so the scan runs upward.
  always_comb begin
    lz = '0;
    for (int i = 0; i < W; i++) begin
      if (mant_i[i]) begin
        lz = LZ_BITS'(W - 1 - i);
      end
    end
  end

  assign new_mant_o = mant_i << lz;
  assign new_te_diff_o = te_diff_i - ppu_pkg::exponent_t'(lz);

endmodule

//--- verilog/posit_encode.sv
/*
  Result stage: builds regime, exponent and fraction, rounds to nearest even
  with saturation, and substitutes special results.
*/
`timescale 1ns/10ps
`include "ppu_defines.svh"

module posit_encode (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  ppu_pkg::normalized_t  normalized_i,
  output ppu_pkg::posit_t       result_o,
  output logic                  valid_o
);

  localparam int FRAC_W = `PPU_MANT_ADD_RESULT_SIZE - 2;
  localparam int SEED_W = FRAC_W + `PPU_ES + 2;
  localparam int PAD_W = `PPU_N;
  localparam int STR_W = SEED_W + PAD_W;
  localparam ppu_pkg::exponent_t MAX_REGIME = `PPU_N - 2;
  localparam ppu_pkg::posit_t MAXPOS = {1'b0, {(`PPU_N-1){1'b1}}};
  localparam ppu_pkg::posit_t MINPOS = 1;

  ppu_pkg::exponent_t regime, shamt;
  logic [SEED_W-3:0] tail;
  logic [SEED_W-1:0] seed;
  logic signed [STR_W-1:0] str;
  logic [`PPU_N-2:0] body;
  logic guard, sticky, round_up;
  ppu_pkg::posit_t rounded, mag, word;

  assign tail = {normalized_i.te[`PPU_ES-1:0], normalized_i.mant[FRAC_W-1:0]};

  always_comb begin
    regime = normalized_i.te >>> `PPU_ES;

    // Arithmetic shift of 10.. or 01.. spreads the regime run.
    shamt = (regime >= 0) ? regime : -regime - 1;
    seed = (regime >= 0) ? {2'b10, tail} : {2'b01, tail};
    str = $signed({seed, {PAD_W{1'b0}}}) >>> shamt;

    body = str[STR_W-1 -: `PPU_N-1];
    guard = str[STR_W-`PPU_N];
    sticky = (|str[STR_W-`PPU_N-1:0]) | normalized_i.frac_truncated;
    round_up = guard & (sticky | body[0]); // Ties to even.
    rounded = {1'b0, body} + ppu_pkg::posit_t'(round_up);

    if (regime >= MAX_REGIME) begin
      mag = MAXPOS;
    end else if (regime < -MAX_REGIME) begin
      mag = MINPOS;
    end else if (rounded[`PPU_N-1]) begin
      mag = MAXPOS; // Never round up into NaR.
    end else begin
      mag = rounded;
    end

    case (normalized_i.special)
      ppu_pkg::SPECIAL_NAR:  word = ppu_pkg::POSIT_NAR;
      ppu_pkg::SPECIAL_ZERO: word = '0;
      ppu_pkg::SPECIAL_PASS: word = normalized_i.pass_value;
      default:               word = normalized_i.sign ? ~mag + 1'b1 : mag;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= word; // Holds between strobes.
      end
    end
  end

endmodule

//--- verilog/posit_operand_decode.sv
/*
  Decode stage: unpacks both posits, flags specials and orders the operands
  so that operand 1 has the larger magnitude.
*/
`timescale 1ns/10ps
`include "ppu_defines.svh"

module posit_operand_decode (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                valid_i,
  input  ppu_pkg::op_e        op_i,
  input  ppu_pkg::posit_t     a_i,
  input  ppu_pkg::posit_t     b_i,
  output ppu_pkg::operands_t  operands_o,
  output logic                valid_o
);

  function automatic void decode_posit(
    input  ppu_pkg::posit_t    p,
    output logic               sign,
    output ppu_pkg::exponent_t te,
    output ppu_pkg::mant_t     mant
  );
    logic [`PPU_N-2:0] u;
    logic [`PPU_N-2:0] rest;
    logic [4:0] run;
    logic run_done;
    ppu_pkg::exponent_t regime;
    sign = p[`PPU_N-1];
    u = sign ? (~p[`PPU_N-2:0] + 1'b1) : p[`PPU_N-2:0];
    run = 5'd1;
    run_done = 1'b0;
    for (int i = `PPU_N-3; i >= 0; i--) begin
      if (!run_done && (u[i] == u[`PPU_N-2])) begin
        run = run + 5'd1;
      end else begin
        run_done = 1'b1;
      end
    end
    regime = u[`PPU_N-2] ? ppu_pkg::exponent_t'(run - 5'd1) : -ppu_pkg::exponent_t'(run);
    rest = u << (run + 5'd1); // Drop regime run and its terminator.
    te = (regime <<< `PPU_ES) + ppu_pkg::exponent_t'(rest[`PPU_N-2 -: `PPU_ES]);
    mant = {1'b1, rest[`PPU_N-2-`PPU_ES -: `PPU_MANT_SIZE-1]};
  endfunction

  ppu_pkg::posit_t b_eff;
  logic sign_a, sign_b;
  ppu_pkg::exponent_t te_a, te_b;
  ppu_pkg::mant_t mant_a, mant_b;
  logic a_larger;
  ppu_pkg::operands_t operands;

  assign b_eff = (op_i == ppu_pkg::OP_SUB) ? ~b_i + 1'b1 : b_i; // Posit negation.

  always_comb begin
    decode_posit(a_i, sign_a, te_a, mant_a);
    decode_posit(b_eff, sign_b, te_b, mant_b);
    a_larger = (te_a > te_b) || ((te_a == te_b) && (mant_a >= mant_b));

    operands.sign1 = a_larger ? sign_a : sign_b;
    operands.sign2 = a_larger ? sign_b : sign_a;
    operands.te1 = a_larger ? te_a : te_b;
    operands.te2 = a_larger ? te_b : te_a;
    operands.mant1 = a_larger ? mant_a : mant_b;
    operands.mant2 = a_larger ? mant_b : mant_a;
    operands.have_opposite_sign = sign_a ^ sign_b;

    operands.pass_value = a_i;
    if (a_i == ppu_pkg::POSIT_NAR || b_eff == ppu_pkg::POSIT_NAR) begin
      operands.special = ppu_pkg::SPECIAL_NAR;
    end else if (a_i == '0) begin
      operands.special = ppu_pkg::SPECIAL_PASS;
      operands.pass_value = b_eff;
    end else if (b_eff == '0) begin
      operands.special = ppu_pkg::SPECIAL_PASS;
    end else if (ppu_pkg::posit_t'(a_i + b_eff) == '0) begin
      operands.special = ppu_pkg::SPECIAL_ZERO; // x - x.
    end else begin
      operands.special = ppu_pkg::SPECIAL_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    operands_o <= operands;
  end

endmodule

//--- verilog/ppu_defines.svh
/*
  Posit add unit configuration: word size, exponent size and derived widths.
*/
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

`define PPU_N 16
`define PPU_ES 1

// Regime and exponent combined, signed.
`define PPU_TE_BITS 7

// Hidden bit plus fraction.
`define PPU_MANT_SIZE 14

`define PPU_MAX_TE_DIFF 16
`define PPU_MANT_ADD_RESULT_SIZE (`PPU_MANT_SIZE + `PPU_MAX_TE_DIFF + 1)
`define PPU_MANT_SUB_RESULT_SIZE (`PPU_MANT_ADD_RESULT_SIZE - 1)

// 1 registers the execute stage, 0 makes it combinational.
`define PIPELINE_STAGE 1

`endif

//--- verilog/ppu_pkg.sv
/*
  Types shared by the posit add pipeline stages.
*/
`include "ppu_defines.svh"

package ppu_pkg;

  typedef logic [`PPU_N-1:0] posit_t;
  typedef logic signed [`PPU_TE_BITS-1:0] exponent_t;
  typedef logic [`PPU_MANT_SIZE-1:0] mant_t;
  typedef logic [`PPU_MANT_ADD_RESULT_SIZE-1:0] mant_sum_t;

  typedef enum logic {OP_ADD, OP_SUB} op_e;

  typedef enum logic [1:0] {
    SPECIAL_NONE,
    SPECIAL_ZERO, // Operands cancel exactly.
    SPECIAL_PASS, // One operand was zero.
    SPECIAL_NAR
  } special_e;

  localparam posit_t POSIT_NAR = {1'b1, {(`PPU_N-1){1'b0}}};

  typedef struct packed {
    logic      sign1;
    logic      sign2;
    exponent_t te1;
    exponent_t te2;
    mant_t     mant1;
    mant_t     mant2;
    logic      have_opposite_sign;
    special_e  special;
    posit_t    pass_value;
  } operands_t;

  typedef struct packed {
    logic      sign;
    exponent_t te;
    mant_sum_t mant;         // Hidden bit at MANT_ADD_RESULT_SIZE-2.
    logic      frac_truncated;
    special_e  special;
    posit_t    pass_value;
  } normalized_t;

endpackage

//--- verilog/ppu_top.sv
/*
  Posit adder/subtractor: decode, execute and result stages, three cycles
  from strobe to result.
*/
`timescale 1ns/10ps

module ppu_top (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  ppu_pkg::op_e     op_i,
  input  ppu_pkg::posit_t  a_i,
  input  ppu_pkg::posit_t  b_i,
  output logic             valid_o,
  output ppu_pkg::posit_t  result_o
);

  ppu_pkg::operands_t operands;
  logic operands_valid;
  ppu_pkg::normalized_t normalized;
  logic normalized_valid;

  posit_operand_decode decode_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .operands_o (operands),
    .valid_o    (operands_valid)
  );

  core_add_sub core_add_sub_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (operands_valid),
    .operands_i   (operands),
    .normalized_o (normalized),
    .valid_o      (normalized_valid)
  );

  posit_encode encode_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (normalized_valid),
    .normalized_i (normalized),
    .result_o     (result_o),
    .valid_o      (valid_o)
  );

endmodule
